//--- rtl/core_pkg.sv
package core_pkg;

	localparam int xlen = 32;
	localparam int reg_count = 16;
	localparam logic [xlen-1:0] reset_pc = '0;

	typedef logic [3:0] reg_addr_t;

	// Major opcodes of the supported subset
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_auipc  = 7'b0010111;
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_jalr   = 7'b1100111;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_op     = 7'b0110011;

	localparam logic [31:0] ebreak_inst = 32'h00100073;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sltu,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_pass_b
	} alu_op_t;

	typedef enum logic [3:0] {
		br_none,
		br_beq,
		br_bne,
		br_blt,
		br_bge,
		br_bltu,
		br_bgeu,
		br_jal,
		br_jalr
	} branch_op_t;

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [31:0]     inst;
	} fetch_payload_t;

	// op_b carries rs1 for JALR, the target base
	typedef struct packed {
		logic [xlen-1:0] pc;
		alu_op_t         alu_op;
		branch_op_t      branch_op;
		logic [xlen-1:0] op_a;
		logic [xlen-1:0] op_b;
		logic [xlen-1:0] imm;
		reg_addr_t       rd;
		logic            we;
		logic            halt;
	} exec_payload_t;

	typedef struct packed {
		logic [xlen-1:0] pc;
		reg_addr_t       rd;
		logic            we;
		logic [xlen-1:0] value;
		logic            halt;
	} result_payload_t;

endpackage

//--- rtl/decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     flush,
	input  logic                     in_valid,
	output logic                     in_ready,
	input  core_pkg::fetch_payload_t in_payload,
	regfile_if.read                  rf,
	input  core_pkg::reg_addr_t      exec_busy_rd,
	input  logic                     exec_busy_we,
	input  core_pkg::reg_addr_t      result_busy_rd,
	input  logic                     result_busy_we,
	output logic                     out_valid,
	input  logic                     out_ready,
	output core_pkg::exec_payload_t  out_payload
);
	import core_pkg::*;

	logic [31:0]     inst;
	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	reg_addr_t       rd;
	reg_addr_t       rs1;
	reg_addr_t       rs2;
	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_b;
	logic [xlen-1:0] imm_u;
	logic [xlen-1:0] imm_j;
	logic            f7_zero;
	logic            f7_alt;
	logic            legal;
	logic            writes;
	logic            uses_rs1;
	logic            uses_rs2;
	logic            hazard;
	logic            stage_ready;
	exec_payload_t   dec;

	assign inst = in_payload.inst;
	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign rd = inst[10:7];   // RV32E, low four index bits
	assign rs1 = inst[18:15];
	assign rs2 = inst[23:20];
	assign f7_zero = funct7 == 7'b0000000;
	assign f7_alt = funct7 == 7'b0100000;

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	assign rf.raddr1 = rs1;
	assign rf.raddr2 = rs2;

	function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: return alt ? alu_sub : alu_add;
			3'b001: return alu_sll;
			3'b010: return alu_slt;
			3'b011: return alu_sltu;
			3'b100: return alu_xor;
			3'b101: return alt ? alu_sra : alu_srl;
			3'b110: return alu_or;
			default: return alu_and;
		endcase
	endfunction

	always_comb begin
		dec = '0;
		dec.pc = in_payload.pc;
		dec.alu_op = alu_add;
		dec.branch_op = br_none;
		dec.op_a = rf.rdata1;
		dec.op_b = rf.rdata2;
		dec.imm = imm_i;
		dec.rd = rd;
		legal = 1'b1;
		writes = 1'b0;
		uses_rs1 = 1'b0;
		uses_rs2 = 1'b0;
		case (opcode)
			opc_lui: begin
				dec.alu_op = alu_pass_b;
				dec.op_b = imm_u;
				writes = 1'b1;
			end
			opc_auipc: begin
				dec.op_a = in_payload.pc;
				dec.op_b = imm_u;
				writes = 1'b1;
			end
			opc_jal: begin
				dec.branch_op = br_jal;
				dec.op_a = in_payload.pc;
				dec.op_b = imm_j;
				dec.imm = imm_j;
				writes = 1'b1;
			end
			opc_jalr: begin
				dec.branch_op = br_jalr;
				dec.op_a = in_payload.pc;
				dec.op_b = rf.rdata1; // Target base
				legal = funct3 == 3'b000;
				writes = 1'b1;
				uses_rs1 = 1'b1;
			end
			opc_branch: begin
				dec.imm = imm_b;
				case (funct3)
					3'b000: dec.branch_op = br_beq;
					3'b001: dec.branch_op = br_bne;
					3'b100: dec.branch_op = br_blt;
					3'b101: dec.branch_op = br_bge;
					3'b110: dec.branch_op = br_bltu;
					3'b111: dec.branch_op = br_bgeu;
					default: legal = 1'b0;
				endcase
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
			end
			opc_op_imm: begin
				dec.alu_op = alu_sel(funct3, funct3 == 3'b101 && f7_alt);
				dec.op_b = imm_i;
				if (funct3 == 3'b001)
					legal = f7_zero;
				else if (funct3 == 3'b101)
					legal = f7_zero || f7_alt;
				writes = 1'b1;
				uses_rs1 = 1'b1;
			end
			opc_op: begin
				dec.alu_op = alu_sel(funct3, f7_alt);
				legal = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
				writes = 1'b1;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
			end
			default: begin
				dec.halt = inst == ebreak_inst;
				legal = 1'b0;
			end
		endcase
		if (!legal) begin
			// Retires as a no-op
			dec.branch_op = br_none;
			writes = 1'b0;
			uses_rs1 = 1'b0;
			uses_rs2 = 1'b0;
		end
		dec.we = writes && rd != '0;
	end

	assign hazard = in_valid && (
		(uses_rs1 && exec_busy_we && exec_busy_rd == rs1) ||
		(uses_rs1 && result_busy_we && result_busy_rd == rs1) ||
		(uses_rs2 && exec_busy_we && exec_busy_rd == rs2) ||
		(uses_rs2 && result_busy_we && result_busy_rd == rs2));

	assign in_ready = stage_ready && !hazard;

	stage_reg #(.payload_t(exec_payload_t)) exec_reg (
		.clock(clock),
		.reset(reset),
		.flush(flush),
		.in_valid(in_valid && !hazard),
		.in_ready(stage_ready),
		.in_payload(dec),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_payload(out_payload)
	);

endmodule

//--- rtl/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      in_valid,
	output logic                      in_ready,
	input  core_pkg::exec_payload_t   in_payload,
	output logic                      out_valid,
	input  logic                      out_ready,
	output core_pkg::result_payload_t out_payload,
	output logic                      redirect_valid,
	output logic [core_pkg::xlen-1:0] redirect_pc,
	output core_pkg::reg_addr_t       busy_rd,
	output logic                      busy_we
);
	import core_pkg::*;

	logic [xlen-1:0] a;
	logic [xlen-1:0] b;
	logic [xlen-1:0] alu_out;
	logic [xlen-1:0] target;
	logic            taken;
	logic            is_jump;
	result_payload_t res;

	assign a = in_payload.op_a;
	assign b = in_payload.op_b;

	always_comb begin
		case (in_payload.alu_op)
			alu_sub: alu_out = a - b;
			alu_and: alu_out = a & b;
			alu_or: alu_out = a | b;
			alu_xor: alu_out = a ^ b;
			alu_slt: alu_out = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
			alu_sltu: alu_out = {{(xlen-1){1'b0}}, a < b};
			alu_sll: alu_out = a << b[4:0];
			alu_srl: alu_out = a >> b[4:0];
			alu_sra: alu_out = $signed(a) >>> b[4:0];
			alu_pass_b: alu_out = b;
			default: alu_out = a + b;
		endcase
	end

	always_comb begin
		case (in_payload.branch_op)
			br_beq: taken = a == b;
			br_bne: taken = a != b;
			br_blt: taken = $signed(a) < $signed(b);
			br_bge: taken = $signed(a) >= $signed(b);
			br_bltu: taken = a < b;
			br_bgeu: taken = a >= b;
			br_jal, br_jalr: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	assign is_jump = in_payload.branch_op == br_jal || in_payload.branch_op == br_jalr;

	always_comb begin
		if (in_payload.branch_op == br_jalr)
			target = (b + in_payload.imm) & ~32'd1;
		else
			target = in_payload.pc + in_payload.imm;
	end

	assign res.pc = in_payload.pc;
	assign res.rd = in_payload.rd;
	assign res.we = in_payload.we;
	assign res.value = is_jump ? in_payload.pc + 32'd4 : alu_out; // Link value
	assign res.halt = in_payload.halt;

	// Only on a transfer, so a stalled branch redirects once
	assign redirect_valid = in_valid && in_ready && taken;
	assign redirect_pc = target;

	assign busy_rd = in_payload.rd;
	assign busy_we = in_valid && in_payload.we;

	stage_reg #(.payload_t(result_payload_t)) result_reg (
		.clock(clock),
		.reset(reset),
		.flush(1'b0),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_payload(res),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_payload(out_payload)
	);

endmodule

//--- rtl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     halt,
	input  logic                     redirect_valid,
	input  logic [core_pkg::xlen-1:0] redirect_pc,
	output logic                     inst_req_valid,
	input  logic                     inst_req_ready,
	output logic [core_pkg::xlen-1:0] inst_addr,
	input  logic                     inst_resp_valid,
	input  logic [31:0]              inst_resp_data,
	output logic                     out_valid,
	input  logic                     out_ready,
	output core_pkg::fetch_payload_t out_payload
);
	import core_pkg::*;

	logic [xlen-1:0] pc; // Stays on the outstanding address until its response
	logic            outstanding;
	logic            stale;
	logic            buf_valid;
	fetch_payload_t  buf_payload;
	fetch_payload_t  resp_payload;
	logic            req_fire;
	logic            resp_live;

	assign req_fire = inst_req_valid && inst_req_ready;
	assign resp_live = inst_resp_valid && !stale;

	// One request at a time, and only with the holding buffer free
	assign inst_req_valid = !reset && !halt && !outstanding && !buf_valid;
	assign inst_addr = pc;

	assign resp_payload.pc = pc;
	assign resp_payload.inst = inst_resp_data;
	assign out_valid = buf_valid || resp_live;
	assign out_payload = buf_valid ? buf_payload : resp_payload;

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= reset_pc;
			outstanding <= 1'b0;
			stale <= 1'b0;
			buf_valid <= 1'b0;
		end else begin
			if (req_fire)
				outstanding <= 1'b1;
			else if (inst_resp_valid)
				outstanding <= 1'b0;

			if (redirect_valid)
				stale <= req_fire || (outstanding && !inst_resp_valid);
			else if (inst_resp_valid)
				stale <= 1'b0;

			if (redirect_valid)
				pc <= redirect_pc;
			else if (resp_live)
				pc <= pc + 32'd4;

			if (redirect_valid)
				buf_valid <= 1'b0; // Wrong-path word
			else if (resp_live && !out_ready)
				buf_valid <= 1'b1;
			else if (out_ready)
				buf_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (resp_live && !out_ready)
			buf_payload <= resp_payload;
	end

	// A response only ever answers the one outstanding request
	assert property (@(posedge clock) disable iff (reset) inst_resp_valid |-> outstanding);

endmodule

//--- rtl/regfile_if.sv
`timescale 1ns/1ps

interface regfile_if;
	import core_pkg::*;

	reg_addr_t       raddr1;
	reg_addr_t       raddr2;
	logic [xlen-1:0] rdata1;
	logic [xlen-1:0] rdata2;
	logic            we;
	reg_addr_t       waddr;
	logic [xlen-1:0] wdata;

	modport read (output raddr1, output raddr2, input rdata1, input rdata2);
	modport write (output we, output waddr, output wdata);
	modport storage (
		input raddr1, input raddr2, output rdata1, output rdata2,
		input we, input waddr, input wdata
	);
endinterface

//--- rtl/register_file.sv
`timescale 1ns/1ps

module register_file (
	input  logic       clock,
	input  logic       reset,
	regfile_if.storage rf
);
	import core_pkg::*;

	logic [xlen-1:0] regs [reg_count];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < reg_count; i++)
				regs[i] <= '0;
		end else if (rf.we && rf.waddr != '0) begin
			regs[rf.waddr] <= rf.wdata;
		end
	end

	assign rf.rdata1 = regs[rf.raddr1];
	assign rf.rdata2 = regs[rf.raddr2];

	// Writeback never targets entry zero
	assert property (@(posedge clock) disable iff (reset) rf.we |-> rf.waddr != '0);

endmodule

//--- rtl/result_unit.sv
`timescale 1ns/1ps

module result_unit (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      in_valid,
	output logic                      in_ready,
	input  core_pkg::result_payload_t in_payload,
	regfile_if.write                  rf,
	output logic                      retire_valid,
	output logic [core_pkg::xlen-1:0] retire_pc,
	output core_pkg::reg_addr_t       retire_rd,
	output logic                      retire_we,
	output logic [core_pkg::xlen-1:0] retire_value,
	output logic                      halt
);

	assign in_ready = 1'b1; // Never back-pressures

	// Items arriving after EBREAK are dropped
	assign retire_valid = in_valid && !halt;
	assign retire_pc = in_payload.pc;
	assign retire_rd = in_payload.rd;
	assign retire_we = in_payload.we;
	assign retire_value = in_payload.value;

	assign rf.we = retire_valid && in_payload.we;
	assign rf.waddr = in_payload.rd;
	assign rf.wdata = in_payload.value;

	always_ff @(posedge clock) begin
		if (reset)
			halt <= 1'b0;
		else if (retire_valid && in_payload.halt)
			halt <= 1'b1;
	end

endmodule

//--- rtl/rv_core.sv
`timescale 1ns/1ps

module rv_core (
	input  logic                      clock,
	input  logic                      reset,
	output logic                      inst_req_valid,
	input  logic                      inst_req_ready,
	output logic [core_pkg::xlen-1:0] inst_addr,
	input  logic                      inst_resp_valid,
	input  logic [31:0]               inst_resp_data,
	output logic                      retire_valid,
	output logic [core_pkg::xlen-1:0] retire_pc,
	output core_pkg::reg_addr_t       retire_rd,
	output logic                      retire_we,
	output logic [core_pkg::xlen-1:0] retire_value,
	output logic                      halt
);
	import core_pkg::*;

	logic            f_valid;
	logic            f_ready;
	fetch_payload_t  f_payload;
	logic            d_valid;
	logic            d_ready;
	fetch_payload_t  d_payload;
	logic            x_valid;
	logic            x_ready;
	exec_payload_t   x_payload;
	logic            r_valid;
	logic            r_ready;
	result_payload_t r_payload;
	logic            redirect_valid;
	logic [xlen-1:0] redirect_pc;
	reg_addr_t       exec_busy_rd;
	logic            exec_busy_we;
	reg_addr_t       result_busy_rd;
	logic            result_busy_we;

	regfile_if rf ();

	assign result_busy_rd = r_payload.rd;
	assign result_busy_we = r_valid && r_payload.we;

	fetch_unit fetch (
		.clock(clock),
		.reset(reset),
		.halt(halt),
		.redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc),
		.inst_req_valid(inst_req_valid),
		.inst_req_ready(inst_req_ready),
		.inst_addr(inst_addr),
		.inst_resp_valid(inst_resp_valid),
		.inst_resp_data(inst_resp_data),
		.out_valid(f_valid),
		.out_ready(f_ready),
		.out_payload(f_payload)
	);

	stage_reg #(.payload_t(fetch_payload_t)) fetch_reg (
		.clock(clock),
		.reset(reset),
		.flush(redirect_valid),
		.in_valid(f_valid),
		.in_ready(f_ready),
		.in_payload(f_payload),
		.out_valid(d_valid),
		.out_ready(d_ready),
		.out_payload(d_payload)
	);

	decode_unit decode (
		.clock(clock),
		.reset(reset),
		.flush(redirect_valid),
		.in_valid(d_valid),
		.in_ready(d_ready),
		.in_payload(d_payload),
		.rf(rf),
		.exec_busy_rd(exec_busy_rd),
		.exec_busy_we(exec_busy_we),
		.result_busy_rd(result_busy_rd),
		.result_busy_we(result_busy_we),
		.out_valid(x_valid),
		.out_ready(x_ready),
		.out_payload(x_payload)
	);

	execute_unit execute (
		.clock(clock),
		.reset(reset),
		.in_valid(x_valid),
		.in_ready(x_ready),
		.in_payload(x_payload),
		.out_valid(r_valid),
		.out_ready(r_ready),
		.out_payload(r_payload),
		.redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc),
		.busy_rd(exec_busy_rd),
		.busy_we(exec_busy_we)
	);

	result_unit result (
		.clock(clock),
		.reset(reset),
		.in_valid(r_valid),
		.in_ready(r_ready),
		.in_payload(r_payload),
		.rf(rf),
		.retire_valid(retire_valid),
		.retire_pc(retire_pc),
		.retire_rd(retire_rd),
		.retire_we(retire_we),
		.retire_value(retire_value),
		.halt(halt)
	);

	register_file regs (
		.clock(clock),
		.reset(reset),
		.rf(rf)
	);

endmodule

//--- rtl/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clock,
	input  logic     reset,
	input  logic     flush,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_payload,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_payload
);

	assign in_ready = !out_valid || out_ready; // Empty, or draining this cycle

	always_ff @(posedge clock) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (flush) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (in_valid && in_ready)
			out_payload <= in_payload;
	end

	assert property (@(posedge clock) disable iff (reset)
		out_valid && !out_ready && !flush |=> out_valid && $stable(out_payload));

endmodule

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f vlog.f --top-module tb_rv_core -o sim_rv_core
./obj_dir/sim_rv_core > sim.log 2>&1 || true
cat sim.log
if grep -q "Test failed" sim.log; then
	exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
	exit 1
fi
exit 0

//--- test/tb_golden.svh
// Instruction encoders, program images and the sequential reference model

function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2, input int rs1,
	input logic [2:0] f3, input int rd);
	return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3, input int rd,
	input int rs1, input int imm);
	return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
endfunction

function automatic logic [31:0] enc_b(input logic [2:0] f3, input int rs1, input int rs2,
	input int off);
	logic [12:0] o;
	o = 13'(off);
	return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_u(input logic [6:0] opc, input int rd, input logic [19:0] imm);
	return {imm, 5'(rd), opc};
endfunction

function automatic logic [31:0] enc_j(input int rd, input int off);
	logic [20:0] o;
	o = 21'(off);
	return {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'b1101111};
endfunction

task automatic append_word(input int t, input logic [31:0] w);
	prog[t][prog_len[t]] = w;
	prog_len[t]++;
endtask

// Outside the image the word is an undefined encoding built from the address
function automatic logic [31:0] fetch_word(input int t, input logic [31:0] addr);
	if (addr < 32'(prog_len[t] * 4))
		return prog[t][addr[7:2]];
	return {addr[31:2], 2'b00};
endfunction

task automatic build_programs();
	// ALU, signed edges, shifts by 31, dependent chains, x0 writes, undefined words
	append_word(0, enc_i(7'h13, 3'd0, 1, 0, -1));
	append_word(0, enc_u(7'h37, 2, 20'h80000));
	append_word(0, enc_r(7'h00, 2, 1, 3'd2, 3));
	append_word(0, enc_r(7'h00, 1, 2, 3'd3, 4));
	append_word(0, enc_i(7'h13, 3'd2, 5, 2, 0));
	append_word(0, enc_i(7'h13, 3'd3, 6, 1, 1));
	append_word(0, enc_i(7'h13, 3'd5, 7, 2, 'h41f)); // srai by 31
	append_word(0, enc_i(7'h13, 3'd5, 8, 2, 31));
	append_word(0, enc_i(7'h13, 3'd1, 9, 1, 31));
	append_word(0, enc_i(7'h13, 3'd0, 11, 0, 31));
	append_word(0, enc_r(7'h00, 11, 8, 3'd1, 12));
	append_word(0, enc_r(7'h00, 11, 2, 3'd5, 13));
	append_word(0, enc_r(7'h20, 11, 2, 3'd5, 14));
	append_word(0, enc_r(7'h00, 8, 1, 3'd0, 15));
	append_word(0, enc_r(7'h20, 1, 15, 3'd0, 3));
	append_word(0, enc_r(7'h00, 2, 1, 3'd7, 4));
	append_word(0, enc_r(7'h00, 2, 3, 3'd6, 5));
	append_word(0, enc_r(7'h00, 1, 5, 3'd4, 6));
	append_word(0, enc_i(7'h13, 3'd7, 7, 6, 'h7f));
	append_word(0, enc_i(7'h13, 3'd6, 8, 7, -2048));
	append_word(0, enc_i(7'h13, 3'd4, 9, 8, 'h555));
	append_word(0, enc_i(7'h13, 3'd0, 10, 9, 1));
	append_word(0, enc_i(7'h13, 3'd0, 10, 10, 1));
	append_word(0, enc_i(7'h13, 3'd0, 10, 10, 1));
	append_word(0, enc_u(7'h17, 11, 20'h12345));
	append_word(0, enc_i(7'h13, 3'd0, 0, 1, 5));
	append_word(0, enc_r(7'h00, 1, 0, 3'd0, 12));
	append_word(0, 32'hffffffff);
	append_word(0, 32'h00000000);
	append_word(0, enc_r(7'h01, 2, 1, 3'd0, 13)); // mul is not part of this core
	append_word(0, enc_r(7'h00, 13, 12, 3'd0, 13));
	append_word(0, 32'h00100073);
	// Branches of all kinds, jumps and a short loop
	append_word(1, enc_i(7'h13, 3'd0, 1, 0, 5));
	append_word(1, enc_i(7'h13, 3'd0, 2, 0, -3));
	append_word(1, enc_b(3'd0, 1, 1, 8));
	append_word(1, enc_i(7'h13, 3'd0, 3, 0, 99));
	append_word(1, enc_b(3'd1, 1, 1, 8));
	append_word(1, enc_i(7'h13, 3'd0, 3, 0, 1));
	append_word(1, enc_b(3'd4, 2, 1, 8));
	append_word(1, enc_i(7'h13, 3'd0, 4, 0, 99));
	append_word(1, enc_b(3'd5, 2, 1, 8));
	append_word(1, enc_i(7'h13, 3'd0, 4, 0, 2));
	append_word(1, enc_b(3'd6, 2, 1, 8));
	append_word(1, enc_i(7'h13, 3'd0, 5, 0, 3));
	append_word(1, enc_b(3'd7, 2, 1, 8));
	append_word(1, enc_i(7'h13, 3'd0, 5, 0, 77));
	append_word(1, enc_b(3'd5, 1, 2, 8));
	append_word(1, enc_i(7'h13, 3'd0, 6, 0, 77));
	append_word(1, enc_b(3'd4, 1, 2, 8));
	append_word(1, enc_j(7, 12));
	append_word(1, enc_i(7'h13, 3'd0, 6, 0, 88));
	append_word(1, enc_i(7'h13, 3'd0, 6, 0, 89));
	append_word(1, enc_u(7'h17, 8, 20'h0));
	append_word(1, enc_i(7'h13, 3'd0, 8, 8, 17)); // Odd base for jalr
	append_word(1, enc_i(7'h67, 3'd0, 9, 8, 0));
	append_word(1, enc_i(7'h13, 3'd0, 10, 0, 55));
	append_word(1, enc_r(7'h00, 7, 9, 3'd0, 11));
	append_word(1, enc_i(7'h13, 3'd0, 12, 0, 3));
	append_word(1, enc_i(7'h13, 3'd0, 12, 12, -1));
	append_word(1, enc_b(3'd1, 12, 0, -4));
	append_word(1, enc_j(0, 8));
	append_word(1, enc_i(7'h13, 3'd0, 13, 0, 1));
	append_word(1, 32'h00100073);
endtask

function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
	input logic [31:0] a, input logic [31:0] b);
	case (f3)
		3'd0: return alt ? a - b : a + b;
		3'd1: return a << b[4:0];
		3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		3'd3: return (a < b) ? 32'd1 : 32'd0;
		3'd4: return a ^ b;
		3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
		3'd6: return a | b;
		default: return a & b;
	endcase
endfunction

task automatic run_golden(input int t);
	logic [31:0] x [16];
	logic [31:0] pc;
	logic [31:0] inst;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] v;
	logic [31:0] imm_i;
	logic [31:0] npc;
	logic [2:0]  f3;
	logic [6:0]  f7;
	logic        w;
	logic        tk;
	retire_rec_t r;
	exp_q.delete();
	foreach (x[i])
		x[i] = '0;
	pc = '0;
	for (int n = 0; n < 1000; n++) begin
		inst = fetch_word(t, pc);
		a = x[inst[18:15]];
		b = x[inst[23:20]];
		f3 = inst[14:12];
		f7 = inst[31:25];
		imm_i = {{20{inst[31]}}, inst[31:20]};
		npc = pc + 32'd4;
		w = 1'b0;
		v = '0;
		tk = 1'b0;
		case (inst[6:0])
			7'h37: begin
				w = 1'b1;
				v = {inst[31:12], 12'b0};
			end
			7'h17: begin
				w = 1'b1;
				v = pc + {inst[31:12], 12'b0};
			end
			7'h6f: begin
				w = 1'b1;
				v = pc + 32'd4;
				npc = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
			end
			7'h67: if (f3 == 3'd0) begin
				w = 1'b1;
				v = pc + 32'd4;
				npc = (a + imm_i) & ~32'd1;
			end
			7'h63: begin
				case (f3)
					3'd0: tk = a == b;
					3'd1: tk = a != b;
					3'd4: tk = $signed(a) < $signed(b);
					3'd5: tk = $signed(a) >= $signed(b);
					3'd6: tk = a < b;
					3'd7: tk = a >= b;
					default: tk = 1'b0;
				endcase
				if (tk)
					npc = pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
			end
			7'h13: if ((f3 != 3'd1 || f7 == 7'h00) &&
				(f3 != 3'd5 || f7 == 7'h00 || f7 == 7'h20)) begin
				w = 1'b1;
				v = ref_alu(f3, f3 == 3'd5 && f7 == 7'h20, a, imm_i);
			end
			7'h33: if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
				w = 1'b1;
				v = ref_alu(f3, f7 == 7'h20, a, b);
			end
			default: w = 1'b0;
		endcase
		r.pc = pc;
		r.rd = inst[10:7];
		r.we = w && inst[10:7] != 4'd0;
		r.value = v;
		exp_q.push_back(r);
		if (inst == 32'h00100073)
			break;
		if (r.we)
			x[inst[10:7]] = v;
		pc = npc;
	end
	load_head();
endtask

//--- test/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

	typedef struct packed {
		logic [31:0] pc;
		logic [3:0]  rd;
		logic        we;
		logic [31:0] value;
	} retire_rec_t;

	logic        clock;
	logic        reset;
	logic        inst_req_valid;
	logic        inst_req_ready;
	logic [31:0] inst_addr;
	logic        inst_resp_valid;
	logic [31:0] inst_resp_data;
	logic        retire_valid;
	logic [31:0] retire_pc;
	logic [3:0]  retire_rd;
	logic        retire_we;
	logic [31:0] retire_value;
	logic        halt;

	logic [31:0] prog [2][64];
	int          prog_len [2];
	string       test_name [2] = '{"alu_and_hazards", "branches_and_jumps"};
	int          cur_test;
	retire_rec_t exp_q [$];
	retire_rec_t head;
	logic        head_ok;
	int          errors;
	int          retired;
	integer      seed = 32'hb0af;

	// Memory model state
	logic        pending;
	int          delay;
	logic [31:0] pend_addr;
	logic        req_seen;
	logic        in_reset;

	rv_core UUT (
		.clock(clock),
		.reset(reset),
		.inst_req_valid(inst_req_valid),
		.inst_req_ready(inst_req_ready),
		.inst_addr(inst_addr),
		.inst_resp_valid(inst_resp_valid),
		.inst_resp_data(inst_resp_data),
		.retire_valid(retire_valid),
		.retire_pc(retire_pc),
		.retire_rd(retire_rd),
		.retire_we(retire_we),
		.retire_value(retire_value),
		.halt(halt)
	);

	task automatic load_head();
		head_ok = exp_q.size() > 0;
		head = head_ok ? exp_q[0] : '0;
	endtask

	`include "tb_golden.svh"

	always #5 clock = ~clock;

	// Random ready, 1 to 4 cycles of response latency
	always @(posedge clock) begin
		in_reset = reset;
		req_seen = inst_req_valid && inst_req_ready && !reset;
		if (req_seen)
			pend_addr = inst_addr;
		#1;
		inst_resp_valid = 1'b0;
		if (in_reset)
			pending = 1'b0;
		if (req_seen) begin
			pending = 1'b1;
			delay = 1 + ($random(seed) & 3);
		end
		if (pending) begin
			delay = delay - 1;
			if (delay == 0) begin
				inst_resp_valid = 1'b1;
				inst_resp_data = fetch_word(cur_test, pend_addr);
				pending = 1'b0;
			end
		end
		inst_req_ready = ($random(seed) & 3) != 0;
	end

	always @(posedge clock) begin
		if (!reset && retire_valid) begin
			retired++;
			if (exp_q.size() > 0)
				void'(exp_q.pop_front());
			load_head();
		end
	end

	task automatic report_mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
		errors++;
		$display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("ERROR at %0t: %s", $time, what);
	endtask

	assert property (@(posedge clock) disable iff (reset) retire_valid |-> head_ok)
		else report_failure("an instruction retired beyond the expected stream");
	assert property (@(posedge clock) disable iff (reset)
		retire_valid && head_ok |-> retire_pc == head.pc)
		else report_mismatch("retire_pc", $sampled(head.pc), $sampled(retire_pc));
	assert property (@(posedge clock) disable iff (reset)
		retire_valid && head_ok |-> retire_we == head.we)
		else report_mismatch("retire_we", 32'($sampled(head.we)), 32'($sampled(retire_we)));
	assert property (@(posedge clock) disable iff (reset)
		retire_valid && head_ok && head.we |-> retire_rd == head.rd)
		else report_mismatch("retire_rd", 32'($sampled(head.rd)), 32'($sampled(retire_rd)));
	assert property (@(posedge clock) disable iff (reset)
		retire_valid && head_ok && head.we |-> retire_value == head.value)
		else report_mismatch("retire_value", $sampled(head.value), $sampled(retire_value));
	assert property (@(posedge clock) disable iff (reset)
		pending || inst_resp_valid |-> !inst_req_valid)
		else report_failure("a request was issued while another was outstanding");
	assert property (@(posedge clock) disable iff (reset) halt |-> !retire_valid && !inst_req_valid)
		else report_failure("activity seen after halt");
	assert property (@(posedge clock) disable iff (reset) halt |=> halt)
		else report_failure("halt dropped without reset");
	assert property (@(posedge clock) disable iff (reset) $rose(halt) |-> !head_ok)
		else report_failure("halted with expected instructions still pending");
	assert property (@(posedge clock)
		reset && $past(reset) |-> !inst_req_valid && !retire_valid && !halt)
		else report_failure("request, retire or halt seen while reset was held");

	task automatic run_watchdog(input int cycles);
		repeat (cycles) @(posedge clock);
		$display("Timeout: the core did not halt within %0d cycles", cycles);
		$display("Test failed");
		$finish;
	endtask

	initial begin
		int e0;
		int r0;
		clock = 1'b0;
		reset = 1'b1;
		inst_req_ready = 1'b0;
		inst_resp_valid = 1'b0;
		inst_resp_data = '0;
		pending = 1'b0;
		errors = 0;
		retired = 0;
		cur_test = 0;
		build_programs();
		fork
			run_watchdog((prog_len[0] + prog_len[1]) * 200 + 100);
		join_none
		for (int t = 0; t < 2; t++) begin
			cur_test = t;
			run_golden(t);
			e0 = errors;
			r0 = retired;
			@(posedge clock);
			#1 reset = 1'b1;
			repeat (3) @(posedge clock);
			#1 reset = 1'b0;
			while (halt !== 1'b1)
				@(posedge clock);
			repeat (20) @(posedge clock); // Must stay quiet after halt
			$display("test %0d %s finished: %0d retired, %0d errors", t, test_name[t],
				retired - r0, errors - e0);
		end
		$display("2 tests, %0d instructions retired, %0d errors", retired, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+test
rtl/core_pkg.sv
rtl/regfile_if.sv
rtl/stage_reg.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/execute_unit.sv
rtl/result_unit.sv
rtl/register_file.sv
rtl/rv_core.sv
test/tb_rv_core.sv
